// File: verilog/prf_pkg.sv
package prf_pkg;

    localparam int tag_w      = 8;
    localparam int num_tags   = 256;
    localparam int num_arch   = 32;    // tags that reset to their own index
    localparam int data_w     = 32;
    localparam int mem_addr_w = 6;     // 64-word data memory
    localparam int mul_depth  = 3;
    localparam int div_steps  = 32;    // one quotient bit per step

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul,
        op_div,
        op_load
    } op_t;

    // writeback payload, also carried by the multiply pipe
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] data;
    } wb_pkt_t;

    // load address pipe payload
    typedef struct packed {
        logic [tag_w-1:0]      tag;
        logic [mem_addr_w-1:0] addr;
    } ld_req_t;

endpackage

// File: verilog/phys_reg_file.sv
`timescale 1ns/10ps

module phys_reg_file import prf_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [tag_w-1:0]  src1,
    input  logic [tag_w-1:0]  src2,
    input  logic [tag_w-1:0]  rd_tag,
    input  logic              clear_en,
    input  logic [tag_w-1:0]  clear_tag,
    input  logic              alu_we,
    input  logic [tag_w-1:0]  alu_tag,
    input  logic [data_w-1:0] alu_data,
    input  logic              mul_we,
    input  logic [tag_w-1:0]  mul_tag,
    input  logic [data_w-1:0] mul_data,
    input  logic              div_we,
    input  logic [tag_w-1:0]  div_tag,
    input  logic [data_w-1:0] div_data,
    input  logic              ld_we,
    input  logic [tag_w-1:0]  ld_tag,
    input  logic [data_w-1:0] ld_data,
    output logic [data_w-1:0] src1_data,
    output logic [data_w-1:0] src2_data,
    output logic [data_w-1:0] rd_data,
    output logic              valid1,
    output logic              valid2,
    output logic              rd_valid
);

    logic [data_w-1:0] regs  [num_tags];
    logic              valid [num_tags];

    logic              wr_en   [4];
    logic [tag_w-1:0]  wr_tag  [4];
    logic [data_w-1:0] wr_data [4];

    // gather the unit ports so one loop serves all four
    assign wr_en   = '{alu_we, mul_we, div_we, ld_we};
    assign wr_tag  = '{alu_tag, mul_tag, div_tag, ld_tag};
    assign wr_data = '{alu_data, mul_data, div_data, ld_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_tags; i++) begin
                regs[i]  <= (i < num_arch) ? data_w'(i) : '0;
                valid[i] <= 1'b1;
            end
        end else begin
            for (int p = 0; p < 4; p++) begin
                if (wr_en[p] && wr_tag[p] != '0) begin   // tag 0 is hardwired
                    regs[wr_tag[p]]  <= wr_data[p];
                    valid[wr_tag[p]] <= 1'b1;
                end
            end
            if (clear_en && clear_tag != '0)
                valid[clear_tag] <= 1'b0;                // last assignment, clear wins
        end
    end

    assign src1_data = regs[src1];
    assign src2_data = regs[src2];
    assign valid1    = valid[src1];
    assign valid2    = valid[src2];
    assign rd_data   = regs[rd_tag];   // retire read
    assign rd_valid  = valid[rd_tag];

endmodule

// File: verilog/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl import prf_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  op_t               op,
    input  logic [tag_w-1:0]  src1_in,
    input  logic [tag_w-1:0]  src2_in,
    input  logic [tag_w-1:0]  dst_in,
    input  logic              valid1,
    input  logic              valid2,
    input  logic [data_w-1:0] src1_data,
    input  logic [data_w-1:0] src2_data,
    input  logic              div_busy,
    output logic              busy,
    output logic [tag_w-1:0]  src1,
    output logic [tag_w-1:0]  src2,
    output logic              clear_en,
    output logic [tag_w-1:0]  clear_tag,
    output logic              alu_go,
    output logic              mul_go,
    output logic              div_go,
    output logic              ld_go,
    output op_t               go_op,
    output logic [tag_w-1:0]  go_tag,
    output logic [data_w-1:0] opa,
    output logic [data_w-1:0] opb
);

    typedef enum logic [1:0] {idle, wait_ops, fire} state_t;

    state_t           state;
    op_t              op_q;
    op_t              chk_op;
    logic [tag_w-1:0] src1_q, src2_q, dst_q;
    logic             accept, ready, firing;

    assign accept = issue && (state == idle);
    assign busy   = (state != idle);
    assign firing = (state == fire);

    // in idle the file looks at the incoming tags so a ready op skips wait_ops
    assign src1   = (state == idle) ? src1_in : src1_q;
    assign src2   = (state == idle) ? src2_in : src2_q;
    assign chk_op = (state == idle) ? op : op_q;
    assign ready  = valid1 && valid2 && !(chk_op == op_div && div_busy);

    assign clear_en  = accept;
    assign clear_tag = dst_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle:     if (issue) state <= ready ? fire : wait_ops;
                wait_ops: if (ready) state <= fire;
                default:  state <= idle;   // fire lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op;
            src1_q <= src1_in;
            src2_q <= src2_in;
            dst_q  <= dst_in;
        end
    end

    assign mul_go = firing && op_q == op_mul;
    assign div_go = firing && op_q == op_div;
    assign ld_go  = firing && op_q == op_load;
    assign alu_go = firing && !(op_q inside {op_mul, op_div, op_load});

    assign go_op  = op_q;
    assign go_tag = dst_q;
    assign opa    = src1_data;   // held tags, both valid while firing
    assign opb    = src2_data;

endmodule

// File: verilog/int_alu.sv
`timescale 1ns/10ps

module int_alu import prf_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              go,
    input  op_t               op,
    input  logic [tag_w-1:0]  tag,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic              we,
    output logic [tag_w-1:0]  wtag,
    output logic [data_w-1:0] wdata
);

    logic [data_w-1:0] result;

    always_comb begin
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_xor:  result = a ^ b;
            default: result = '0;   // unused code
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            we <= 1'b0;
        else
            we <= go;
    end

    always_ff @(posedge clk) begin
        if (go) begin
            wtag  <= tag;
            wdata <= result;
        end
    end

endmodule

// File: verilog/result_pipe.sv
`timescale 1ns/10ps

module result_pipe #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic     valid_q [depth];
    payload_t data_q  [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++)
                valid_q[i] <= 1'b0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < depth; i++)
                valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < depth; i++)
            data_q[i] <= data_q[i-1];   // shifts every cycle, valid tags it
    end

    assign out_valid = valid_q[depth-1];
    assign out_data  = data_q[depth-1];

endmodule

// File: verilog/load_mem.sv
`timescale 1ns/10ps

module load_mem import prf_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  ld_req_t               req,
    input  logic                  mem_we,
    input  logic [mem_addr_w-1:0] mem_addr,
    input  logic [data_w-1:0]     mem_wdata,
    output logic                  we,
    output logic [tag_w-1:0]      wtag,
    output logic [data_w-1:0]     wdata
);

    localparam int num_words = 1 << mem_addr_w;

    logic [data_w-1:0] mem [num_words];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_words; i++)
                mem[i] <= '0;
        end else if (mem_we) begin
            mem[mem_addr] <= mem_wdata;   // fill port from outside
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            we <= 1'b0;
        else
            we <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            wtag  <= req.tag;
            wdata <= mem[req.addr];
        end
    end

endmodule

// File: verilog/div_counter.sv
`timescale 1ns/10ps

module div_counter import prf_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic running,
    output logic last
);

    localparam int cnt_w = $clog2(div_steps + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (start)
            count <= cnt_w'(div_steps);
        else if (count != '0)
            count <= count - cnt_w'(1);
    end

    assign running = (count != '0);
    assign last    = (count == cnt_w'(1));   // final step

endmodule

// File: verilog/div_unit.sv
`timescale 1ns/10ps

module div_unit import prf_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              go,
    input  logic [tag_w-1:0]  tag,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic              busy,
    output logic              we,
    output logic [tag_w-1:0]  wtag,
    output logic [data_w-1:0] wdata
);

    logic [data_w-1:0] quo_q, rem_q, dvs_q;
    logic [tag_w-1:0]  tag_q;
    logic [data_w:0]   rem_sh, diff;
    logic [data_w-1:0] quo_nx, rem_nx;
    logic              running, last;

    div_counter u_cnt (
        .clk     (clk),
        .reset   (reset),
        .start   (go),
        .running (running),
        .last    (last)
    );

    // one restoring step; a zero divisor never borrows, so the quotient is all ones
    always_comb begin
        rem_sh = {rem_q, quo_q[data_w-1]};
        diff   = rem_sh - {1'b0, dvs_q};
        if (diff[data_w]) begin   // borrow, keep the remainder
            rem_nx = rem_sh[data_w-1:0];
            quo_nx = {quo_q[data_w-2:0], 1'b0};
        end else begin
            rem_nx = diff[data_w-1:0];
            quo_nx = {quo_q[data_w-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            quo_q <= a;   // dividend shifts out as the quotient shifts in
            rem_q <= '0;
            dvs_q <= b;
            tag_q <= tag;
        end else if (running) begin
            quo_q <= quo_nx;
            rem_q <= rem_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            we <= 1'b0;
        else
            we <= running && last;
    end

    always_ff @(posedge clk) begin
        if (running && last) begin
            wtag  <= tag_q;
            wdata <= quo_nx;
        end
    end

    assign busy = running;

endmodule

// File: verilog/exec_backend.sv
`timescale 1ns/10ps

module exec_backend import prf_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue,
    input  op_t                   op,
    input  logic [tag_w-1:0]      src1,
    input  logic [tag_w-1:0]      src2,
    input  logic [tag_w-1:0]      dst,
    input  logic                  mem_we,
    input  logic [mem_addr_w-1:0] mem_addr,
    input  logic [data_w-1:0]     mem_wdata,
    input  logic [tag_w-1:0]      rd_tag,
    output logic                  busy,
    output logic [data_w-1:0]     rd_data,
    output logic                  rd_valid
);

    logic [tag_w-1:0]  prf_src1, prf_src2, clear_tag, go_tag;
    logic [data_w-1:0] src1_data, src2_data, opa, opb;
    logic              valid1, valid2, clear_en, div_busy;
    logic              alu_go, mul_go, div_go, ld_go;
    op_t               go_op;

    logic              alu_we, div_we, ld_we, mul_we, ld_req_valid;
    logic [tag_w-1:0]  alu_tag, div_tag, ld_tag;
    logic [data_w-1:0] alu_data, div_data, ld_data;
    wb_pkt_t           mul_in, mul_out;
    ld_req_t           ld_in, ld_req;

    assign mul_in.tag  = go_tag;
    assign mul_in.data = opa * opb;   // low word of the product
    assign ld_in.tag   = go_tag;
    assign ld_in.addr  = opa[mem_addr_w-1:0];

    phys_reg_file u_prf (
        .clk (clk), .reset (reset),
        .src1 (prf_src1), .src2 (prf_src2), .rd_tag (rd_tag),
        .clear_en (clear_en), .clear_tag (clear_tag),
        .alu_we (alu_we), .alu_tag (alu_tag), .alu_data (alu_data),
        .mul_we (mul_we), .mul_tag (mul_out.tag), .mul_data (mul_out.data),
        .div_we (div_we), .div_tag (div_tag), .div_data (div_data),
        .ld_we (ld_we), .ld_tag (ld_tag), .ld_data (ld_data),
        .src1_data (src1_data), .src2_data (src2_data), .rd_data (rd_data),
        .valid1 (valid1), .valid2 (valid2), .rd_valid (rd_valid)
    );

    issue_ctrl u_ctrl (
        .clk (clk), .reset (reset), .issue (issue), .op (op),
        .src1_in (src1), .src2_in (src2), .dst_in (dst),
        .valid1 (valid1), .valid2 (valid2),
        .src1_data (src1_data), .src2_data (src2_data), .div_busy (div_busy),
        .busy (busy), .src1 (prf_src1), .src2 (prf_src2),
        .clear_en (clear_en), .clear_tag (clear_tag),
        .alu_go (alu_go), .mul_go (mul_go), .div_go (div_go), .ld_go (ld_go),
        .go_op (go_op), .go_tag (go_tag), .opa (opa), .opb (opb)
    );

    int_alu u_alu (
        .clk (clk), .reset (reset), .go (alu_go), .op (go_op), .tag (go_tag),
        .a (opa), .b (opb), .we (alu_we), .wtag (alu_tag), .wdata (alu_data)
    );

    result_pipe #(.payload_t (wb_pkt_t), .depth (mul_depth)) u_mul_pipe (
        .clk (clk), .reset (reset), .in_valid (mul_go), .in_data (mul_in),
        .out_valid (mul_we), .out_data (mul_out)
    );

    result_pipe #(.payload_t (ld_req_t), .depth (1)) u_ld_pipe (
        .clk (clk), .reset (reset), .in_valid (ld_go), .in_data (ld_in),
        .out_valid (ld_req_valid), .out_data (ld_req)
    );

    load_mem u_ld_mem (
        .clk (clk), .reset (reset), .req_valid (ld_req_valid), .req (ld_req),
        .mem_we (mem_we), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
        .we (ld_we), .wtag (ld_tag), .wdata (ld_data)
    );

    div_unit u_div (
        .clk (clk), .reset (reset), .go (div_go), .tag (go_tag),
        .a (opa), .b (opb), .busy (div_busy),
        .we (div_we), .wtag (div_tag), .wdata (div_data)
    );

endmodule

// File: sim/exec_backend_assert.sv
`timescale 1ns/10ps

module exec_backend_assert import prf_pkg::*; (
    input logic             clk,
    input logic             reset,
    input logic             busy,
    input logic             div_go,
    input logic             div_busy,
    input logic             alu_we,
    input logic [tag_w-1:0] alu_tag,
    input logic             mul_we,
    input wb_pkt_t          mul_pkt,
    input logic             div_we,
    input logic [tag_w-1:0] div_tag,
    input logic             ld_we,
    input logic [tag_w-1:0] ld_tag
);

    logic dup_write;

    function automatic logic same_tag(input logic we_a, input logic [tag_w-1:0] tag_a,
                                      input logic we_b, input logic [tag_w-1:0] tag_b);
        return we_a && we_b && tag_a == tag_b && tag_a != '0;
    endfunction

    assign dup_write = same_tag(alu_we, alu_tag, mul_we, mul_pkt.tag)
                    || same_tag(alu_we, alu_tag, div_we, div_tag)
                    || same_tag(alu_we, alu_tag, ld_we, ld_tag)
                    || same_tag(mul_we, mul_pkt.tag, div_we, div_tag)
                    || same_tag(mul_we, mul_pkt.tag, ld_we, ld_tag)
                    || same_tag(div_we, div_tag, ld_we, ld_tag);

    a_no_dup_write: assert property (@(posedge clk) disable iff (reset) !dup_write)
        else $error("two write ports hit the same tag in one cycle");

    a_div_go_free: assert property (@(posedge clk) disable iff (reset) div_busy |-> !div_go)
        else $error("div_go raised while the divider is busy");

    a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy)
        else $error("busy high in the first cycle after reset");

endmodule

bind exec_backend exec_backend_assert u_assert (
    .clk (clk), .reset (reset), .busy (busy),
    .div_go (div_go), .div_busy (div_busy),
    .alu_we (alu_we), .alu_tag (alu_tag),
    .mul_we (mul_we), .mul_pkt (mul_out),
    .div_we (div_we), .div_tag (div_tag),
    .ld_we (ld_we), .ld_tag (ld_tag)
);

// File: sim/tb_exec_backend.sv
`timescale 1ns/10ps

module tb_exec_backend import prf_pkg::*; ();

    localparam int timeout_cycles = 2000;   // longest test sequence with wide margin

    logic                  clk;
    logic                  reset;
    logic                  issue;
    op_t                   op;
    logic [tag_w-1:0]      src1, src2, dst, rd_tag;
    logic                  mem_we;
    logic [mem_addr_w-1:0] mem_addr;
    logic [data_w-1:0]     mem_wdata;
    logic                  busy;
    logic [data_w-1:0]     rd_data;
    logic                  rd_valid;

    logic [data_w-1:0] exp_regs  [num_tags];          // expected register contents
    logic [data_w-1:0] mem_model [1 << mem_addr_w];
    logic [31:0]       lfsr_state;
    int                cycles;

    exec_backend u_dut (
        .clk (clk), .reset (reset), .issue (issue), .op (op),
        .src1 (src1), .src2 (src2), .dst (dst),
        .mem_we (mem_we), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
        .rd_tag (rd_tag), .busy (busy), .rd_data (rd_data), .rd_valid (rd_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles)
            abort_run("timeout: the run did not finish within the cycle limit");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [data_w-1:0] w);
        w = '0;
        for (int i = 0; i < data_w; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[data_w-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [data_w-1:0] model_result(input op_t o,
                                                       input logic [data_w-1:0] a,
                                                       input logic [data_w-1:0] b);
        case (o)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_xor:  return a ^ b;
            op_mul:  return a * b;
            op_div:  return (b == '0) ? '1 : a / b;
            default: return mem_model[a[mem_addr_w-1:0]];   // load
        endcase
    endfunction

    task automatic check_data(input string name, input logic [data_w-1:0] expected,
                              input logic [data_w-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b",
                                name, expected, actual));
    endtask

    task automatic do_issue(input op_t o, input logic [tag_w-1:0] s1,
                            input logic [tag_w-1:0] s2, input logic [tag_w-1:0] d);
        @(posedge clk);
        #1;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        issue = 1'b1;
        op    = o;
        src1  = s1;
        src2  = s2;
        dst   = d;
        if (d != '0)
            exp_regs[d] = model_result(o, exp_regs[s1], exp_regs[s2]);
        @(posedge clk);   // accepted here
        #1;
        issue = 1'b0;
        check_valid("busy after accept", 1'b1, busy);
    endtask

    task automatic wait_ready(input logic [tag_w-1:0] t);
        @(posedge clk);
        #1;
        rd_tag = t;
        #1;
        while (!rd_valid) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_reg(input string name, input logic [tag_w-1:0] t);
        @(posedge clk);
        #1;
        rd_tag = t;
        #1;
        check_valid({name, " valid"}, 1'b1, rd_valid);
        check_data(name, exp_regs[t], rd_data);
    endtask

    task automatic check_result(input string name, input logic [tag_w-1:0] t);
        wait_ready(t);
        check_reg(name, t);
    endtask

    task automatic fill_mem(input logic [mem_addr_w-1:0] a);
        logic [data_w-1:0] w;
        random_word(w);
        mem_model[a] = w;
        @(posedge clk);
        #1;
        mem_we    = 1'b1;
        mem_addr  = a;
        mem_wdata = w;
        @(posedge clk);
        #1;
        mem_we = 1'b0;
    endtask

    task automatic test_reset();
        for (int i = 0; i < num_arch; i++)
            check_reg($sformatf("reset tag %0d", i), tag_w'(i));
        check_reg("reset tag 32", 8'd32);
        check_reg("reset tag 100", 8'd100);
        check_reg("reset tag 255", 8'd255);
    endtask

    // loads bring random words into tags 64..71 for the later tests
    task automatic test_load();
        for (int i = 1; i <= 8; i++)
            fill_mem(mem_addr_w'(i));
        fill_mem(6'd45);
        do_issue(op_add, 8'd20, 8'd25, 8'd50);   // address 45
        for (int i = 0; i < 8; i++)
            do_issue(op_load, tag_w'(i + 1), 8'd0, tag_w'(64 + i));
        do_issue(op_load, 8'd50, 8'd0, 8'd63);
        for (int i = 0; i < 8; i++)
            check_result($sformatf("load tag %0d", 64 + i), tag_w'(64 + i));
        check_result("load via computed address", 8'd63);
    endtask

    task automatic test_alu();
        do_issue(op_add, 8'd64, 8'd65, 8'd80);
        do_issue(op_sub, 8'd66, 8'd67, 8'd81);
        do_issue(op_and, 8'd68, 8'd69, 8'd82);
        do_issue(op_xor, 8'd70, 8'd71, 8'd83);
        check_result("alu add", 8'd80);
        check_result("alu sub", 8'd81);
        check_result("alu and", 8'd82);
        check_result("alu xor", 8'd83);
        do_issue(op_and, 8'd65, 8'd31, 8'd85);   // small divisor
        do_issue(op_div, 8'd64, 8'd85, 8'd84);
        do_issue(op_add, 8'd84, 8'd66, 8'd86);   // waits on the divide
        check_result("dependent add", 8'd86);
        check_result("divide feeding add", 8'd84);
    endtask

    task automatic test_mul();
        do_issue(op_mul, 8'd64, 8'd65, 8'd90);
        do_issue(op_mul, 8'd66, 8'd67, 8'd91);
        do_issue(op_mul, 8'd68, 8'd69, 8'd92);
        do_issue(op_add, 8'd70, 8'd71, 8'd93);
        check_result("mul first", 8'd90);
        check_result("mul second", 8'd91);
        check_result("mul third", 8'd92);
        check_result("add after muls", 8'd93);
    endtask

    task automatic test_div();
        do_issue(op_and, 8'd67, 8'd31, 8'd95);
        do_issue(op_div, 8'd68, 8'd95, 8'd96);
        do_issue(op_div, 8'd69, 8'd32, 8'd97);   // zero divisor while the divider is busy
        do_issue(op_div, 8'd70, 8'd71, 8'd98);
        check_result("div small divisor", 8'd96);
        check_result("div by zero", 8'd97);
        check_result("div random", 8'd98);
    endtask

    task automatic test_valid();
        do_issue(op_mul, 8'd64, 8'd66, 8'd110);
        rd_tag = 8'd110;
        #1;
        check_valid("mul dst pending", 1'b0, rd_valid);
        check_result("mul dst written", 8'd110);
        do_issue(op_add, 8'd5, 8'd7, 8'd0);
        do_issue(op_add, 8'd3, 8'd4, 8'd111);
        check_result("add after tag 0 write", 8'd111);
        check_reg("tag 0", 8'd0);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        issue      = 1'b0;
        op         = op_add;
        src1       = '0;
        src2       = '0;
        dst        = '0;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        rd_tag     = '0;
        cycles     = 0;
        lfsr_state = 32'h15d75737;
        for (int i = 0; i < num_tags; i++)
            exp_regs[i] = (i < num_arch) ? data_w'(i) : '0;
        for (int i = 0; i < (1 << mem_addr_w); i++)
            mem_model[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset();
        test_load();
        test_alu();
        test_mul();
        test_div();
        test_valid();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: list.f
verilog/prf_pkg.sv
verilog/phys_reg_file.sv
verilog/issue_ctrl.sv
verilog/int_alu.sv
verilog/result_pipe.sv
verilog/load_mem.sv
verilog/div_counter.sv
verilog/div_unit.sv
verilog/exec_backend.sv
sim/exec_backend_assert.sv
sim/tb_exec_backend.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the exec_backend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_exec_backend \
    && ./obj_dir/Vtb_exec_backend | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
